/* Makefile */
# Verilator build and run for the pointer allocator

VERILATOR ?= verilator
TOP       ?= ptr_bv_allocator_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sources.f */
src/alloc_pkg.sv
src/alloc_fsm_pkg.sv
src/ptr_fifo.sv
src/bv_ram.sv
src/bv_ram_arbiter.sv
src/free_scanner.sv
src/ptr_update_engine.sv
src/ptr_bv_allocator.sv
verification/ptr_bv_allocator_properties.sv
verification/ptr_bv_allocator_tb.sv

/* src/alloc_fsm_pkg.sv */
// ------------------------------------------------
// State encodings for the update engine and scanner
// ------------------------------------------------
`default_nettype none

package alloc_fsm_pkg;

    // Update engine, read-modify-write of one bit
    typedef enum logic [3:0] {
        RESET, IDLE, ALLOC, DEALLOC,
        RD_REQ, RD_WAIT, MODIFY,
        WR, DONE, ERROR
    } upd_state_t;

    // Free-pointer scanner
    typedef enum logic [2:0] {
        SCAN_RESET, SCAN_IDLE, SCAN_RD_REQ, SCAN_RD_WAIT,
        SCAN_CHECK, SCAN_NEXT, SCAN_HOLD
    } scan_state_t;

endpackage

`default_nettype wire

/* src/alloc_pkg.sv */
// ------------------------------------------------
// Pointer pool geometry
// 256 pointers kept as a 16 x 16 bit-vector RAM
// ------------------------------------------------
`default_nettype none

package alloc_pkg;

    // Pool dimensions
    parameter int PTR_WID  = 8;
    parameter int NUM_COLS = 16;
    parameter int NUM_ROWS = 16;
    parameter int COL_WID  = 4;
    parameter int ROW_WID  = 4;

    // Pointer is {row, col}
    typedef logic [PTR_WID-1:0]  ptr_t;
    typedef logic [ROW_WID-1:0]  row_t;
    typedef logic [COL_WID-1:0]  col_t;
    // One RAM row, set bit = free pointer
    typedef logic [NUM_COLS-1:0] vec_t;

endpackage

`default_nettype wire

/* src/bv_ram.sv */
// ------------------------------------------------
// Bit-vector RAM, one write and one read port
// Filled with all ones after reset, then init_done
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bv_ram (
    input  logic            clk,
    input  logic            local_srst,
    input  logic            wr,
    input  alloc_pkg::row_t wr_row,
    input  alloc_pkg::vec_t wr_data,
    input  alloc_pkg::row_t rd_row,
    output alloc_pkg::vec_t rd_data,
    output logic            init_done
);
    import alloc_pkg::*;

    vec_t mem [NUM_ROWS];
    row_t fill_row;

    // Fill counter, one row per cycle
    always_ff @(posedge clk) begin
        if (local_srst) begin
            fill_row  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            fill_row <= fill_row + 1'b1;
            // Last row written this cycle
            if (fill_row == row_t'(NUM_ROWS - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Write port, fill has the port until init_done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[fill_row] <= '1;
        end else if (wr) begin
            mem[wr_row] <= wr_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_row];
    end

endmodule

`default_nettype wire

/* src/bv_ram_arbiter.sv */
// ------------------------------------------------
// Read port arbiter for the bit-vector RAM
// Update engine has fixed priority over scanner
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module bv_ram_arbiter (
    input  logic            clk,
    input  logic            local_srst,
    input  logic            upd_rd_req,
    input  alloc_pkg::row_t upd_rd_row,
    output logic            upd_rd_ack,
    input  logic            scan_rd_req,
    input  alloc_pkg::row_t scan_rd_row,
    output logic            scan_rd_gnt,
    output logic            scan_rd_ack,
    output alloc_pkg::row_t rd_row
);

    // Read in flight and its owner
    logic rd_vld;
    logic rd_scan;

    // Scanner only when engine is quiet
    assign scan_rd_gnt = scan_rd_req && !upd_rd_req;
    assign rd_row      = upd_rd_req ? upd_rd_row : scan_rd_row;

    // One-stage tag delay, matches RAM read latency
    always_ff @(posedge clk) begin
        if (local_srst) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= upd_rd_req || scan_rd_gnt;
        end
    end

    always_ff @(posedge clk) begin
        rd_scan <= !upd_rd_req;
    end

    // Ack goes back to the owner only
    assign upd_rd_ack  = rd_vld && !rd_scan;
    assign scan_rd_ack = rd_vld &&  rd_scan;

endmodule

`default_nettype wire

/* src/free_scanner.sv */
// ------------------------------------------------
// Free-pointer scanner
// Walks RAM rows in order and holds one candidate
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module free_scanner (
    input  logic            clk,
    input  logic            local_srst,
    input  logic            init_done,
    output logic            scan_rd_req,
    output alloc_pkg::row_t scan_rd_row,
    input  logic            scan_rd_gnt,
    input  logic            scan_rd_ack,
    input  alloc_pkg::vec_t rd_data,
    output logic            cand_valid,
    output alloc_pkg::ptr_t cand_ptr,
    input  logic            cand_take
);
    import alloc_pkg::*;
    import alloc_fsm_pkg::*;

    scan_state_t state;
    scan_state_t nxt_state;
    row_t        scan_row;
    vec_t        scan_vec;
    col_t        scan_col;
    col_t        free_col;
    logic        hit;

    always_ff @(posedge clk) begin
        if (local_srst) state <= SCAN_RESET;
        else            state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            SCAN_RESET:   if (init_done) nxt_state = SCAN_IDLE;
            SCAN_IDLE:    nxt_state = SCAN_RD_REQ;
            SCAN_RD_REQ:  if (scan_rd_gnt) nxt_state = SCAN_RD_WAIT;
            SCAN_RD_WAIT: if (scan_rd_ack) nxt_state = SCAN_CHECK;
            SCAN_CHECK:   nxt_state = hit ? SCAN_HOLD : SCAN_NEXT;
            SCAN_NEXT:    nxt_state = SCAN_IDLE;
            // Recheck same row after a take
            SCAN_HOLD:    if (cand_take) nxt_state = SCAN_CHECK;
            default:      nxt_state = SCAN_RESET;
        endcase
    end

    // Row counter, wraps at the last row
    always_ff @(posedge clk) begin
        if (local_srst) begin
            scan_row <= '0;
        end else if (state == SCAN_NEXT) begin
            scan_row <= scan_row + 1'b1;
        end
    end

    // Local row copy, taken bit cleared
    always_ff @(posedge clk) begin
        if (scan_rd_ack) begin
            scan_vec <= rd_data;
        end else if (state == SCAN_HOLD && cand_take) begin
            scan_vec[scan_col] <= 1'b0;
        end
    end

    // Lowest set column wins
    always_comb begin
        hit      = 1'b0;
        free_col = '0;
        for (int i = NUM_COLS - 1; i >= 0; i--) begin
            if (scan_vec[i]) begin
                hit      = 1'b1;
                free_col = col_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_CHECK) scan_col <= free_col;
    end

    // Registered valid, low two cycles after a take
    always_ff @(posedge clk) begin
        if (local_srst) cand_valid <= 1'b0;
        else            cand_valid <= (state == SCAN_HOLD) && !cand_take;
    end

    assign scan_rd_req = (state == SCAN_RD_REQ);
    assign scan_rd_row = scan_row;
    assign cand_ptr    = {scan_row, scan_col};

endmodule

`default_nettype wire

/* src/ptr_bv_allocator.sv */
// ------------------------------------------------
// Top level of the bit-vector pointer allocator
// Queues, RAM, arbiter, scanner and update engine
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ptr_bv_allocator #(
    parameter int ALLOC_Q_DEPTH   = 32,
    parameter int DEALLOC_Q_DEPTH = 32
) (
    input  logic            clk,
    input  logic            local_srst,
    input  logic            en,
    output logic            init_done,
    input  logic            alloc_req,
    output logic            alloc_rdy,
    output alloc_pkg::ptr_t alloc_ptr,
    input  logic            dealloc_req,
    output logic            dealloc_rdy,
    input  alloc_pkg::ptr_t dealloc_ptr,
    output logic            err_alloc,
    output logic            err_dealloc,
    output alloc_pkg::ptr_t err_ptr
);
    import alloc_pkg::*;

    // Queues
    logic aq_wr, aq_full, aq_empty;
    ptr_t aq_ptr;
    logic dq_rd, dq_full, dq_empty;
    ptr_t dq_ptr;
    logic alloc, dealloc;
    // RAM ports
    logic wr;
    row_t wr_row, rd_row;
    vec_t wr_data, rd_data;
    // Read arbitration
    logic upd_rd_req, upd_rd_ack;
    row_t upd_rd_row, scan_rd_row;
    logic scan_rd_req, scan_rd_gnt, scan_rd_ack;
    // Candidate handoff
    logic cand_valid, cand_take;
    ptr_t cand_ptr;

    // Ready gating
    assign alloc_rdy   = en && !aq_empty;
    assign dealloc_rdy = en && init_done && !dq_full;
    assign alloc       = alloc_req && alloc_rdy;
    assign dealloc     = dealloc_req && dealloc_rdy;

    ptr_fifo #(.DEPTH(ALLOC_Q_DEPTH)) alloc_q_i (
        .clk(clk), .local_srst(local_srst),
        .wr(aq_wr), .wr_data(aq_ptr), .rd(alloc), .rd_data(alloc_ptr),
        .full(aq_full), .empty(aq_empty)
    );

    ptr_fifo #(.DEPTH(DEALLOC_Q_DEPTH)) dealloc_q_i (
        .clk(clk), .local_srst(local_srst),
        .wr(dealloc), .wr_data(dealloc_ptr), .rd(dq_rd), .rd_data(dq_ptr),
        .full(dq_full), .empty(dq_empty)
    );

    bv_ram bv_ram_i (
        .clk(clk), .local_srst(local_srst), .wr(wr), .wr_row(wr_row),
        .wr_data(wr_data), .rd_row(rd_row), .rd_data(rd_data), .init_done(init_done)
    );

    bv_ram_arbiter arbiter_i (
        .clk(clk), .local_srst(local_srst),
        .upd_rd_req(upd_rd_req), .upd_rd_row(upd_rd_row), .upd_rd_ack(upd_rd_ack),
        .scan_rd_req(scan_rd_req), .scan_rd_row(scan_rd_row),
        .scan_rd_gnt(scan_rd_gnt), .scan_rd_ack(scan_rd_ack), .rd_row(rd_row)
    );

    free_scanner scanner_i (
        .clk(clk), .local_srst(local_srst), .init_done(init_done),
        .scan_rd_req(scan_rd_req), .scan_rd_row(scan_rd_row),
        .scan_rd_gnt(scan_rd_gnt), .scan_rd_ack(scan_rd_ack), .rd_data(rd_data),
        .cand_valid(cand_valid), .cand_ptr(cand_ptr), .cand_take(cand_take)
    );

    ptr_update_engine engine_i (
        .clk(clk), .local_srst(local_srst), .init_done(init_done),
        .dq_empty(dq_empty), .dq_ptr(dq_ptr), .dq_rd(dq_rd),
        .aq_full(aq_full), .aq_wr(aq_wr), .aq_ptr(aq_ptr),
        .cand_valid(cand_valid), .cand_ptr(cand_ptr), .cand_take(cand_take),
        .upd_rd_req(upd_rd_req), .upd_rd_row(upd_rd_row), .upd_rd_ack(upd_rd_ack),
        .rd_data(rd_data), .wr(wr), .wr_row(wr_row), .wr_data(wr_data),
        .err_alloc(err_alloc), .err_dealloc(err_dealloc), .err_ptr(err_ptr)
    );

endmodule

`default_nettype wire

/* src/ptr_fifo.sv */
// ------------------------------------------------
// Pointer FIFO, first-word-fall-through output
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ptr_fifo #(
    parameter int DEPTH = 32
) (
    input  logic            clk,
    input  logic            local_srst,
    input  logic            wr,
    input  alloc_pkg::ptr_t wr_data,
    input  logic            rd,
    output alloc_pkg::ptr_t rd_data,
    output logic            full,
    output logic            empty
);
    import alloc_pkg::*;

    localparam int AWID = $clog2(DEPTH);
    localparam logic [AWID:0] FULL_CNT = (AWID+1)'(DEPTH);

    ptr_t            mem [DEPTH];
    logic [AWID-1:0] wr_idx;
    logic [AWID-1:0] rd_idx;
    logic [AWID:0]   count;
    logic            do_wr;
    logic            do_rd;

    // Guard against overflow and underflow
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (local_srst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_idx <= wr_idx + 1'b1;
            if (do_rd) rd_idx <= rd_idx + 1'b1;
            // Occupancy
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_idx] <= wr_data;
    end

    // Head entry visible without a read
    assign rd_data = mem[rd_idx];
    assign full    = (count == FULL_CNT);
    assign empty   = (count == '0);

endmodule

`default_nettype wire

/* src/ptr_update_engine.sv */
// ------------------------------------------------
// Update engine, read-modify-write of one free bit
// Dealloc sets the bit, alloc clears it
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ptr_update_engine (
    input  logic            clk,
    input  logic            local_srst,
    input  logic            init_done,
    input  logic            dq_empty,
    input  alloc_pkg::ptr_t dq_ptr,
    output logic            dq_rd,
    input  logic            aq_full,
    output logic            aq_wr,
    output alloc_pkg::ptr_t aq_ptr,
    input  logic            cand_valid,
    input  alloc_pkg::ptr_t cand_ptr,
    output logic            cand_take,
    output logic            upd_rd_req,
    output alloc_pkg::row_t upd_rd_row,
    input  logic            upd_rd_ack,
    input  alloc_pkg::vec_t rd_data,
    output logic            wr,
    output alloc_pkg::row_t wr_row,
    output alloc_pkg::vec_t wr_data,
    output logic            err_alloc,
    output logic            err_dealloc,
    output alloc_pkg::ptr_t err_ptr
);
    import alloc_pkg::*;
    import alloc_fsm_pkg::*;

    upd_state_t state;
    upd_state_t nxt_state;
    ptr_t       ptr;
    logic       is_alloc;
    row_t       ptr_row;
    col_t       ptr_col;
    vec_t       colmask;
    vec_t       rd_vec;
    logic       modify_err;

    // ------------------------------------------------
    // FSM
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) state <= RESET;
        else            state <= nxt_state;
    end

    always_comb begin
        nxt_state  = state;
        dq_rd      = 1'b0;
        aq_wr      = 1'b0;
        cand_take  = 1'b0;
        upd_rd_req = 1'b0;
        wr         = 1'b0;
        case (state)
            RESET: if (init_done) nxt_state = IDLE;
            IDLE: begin
                // Deallocation first
                if (!dq_empty) begin
                    nxt_state = DEALLOC;
                end else if (cand_valid && !aq_full) begin
                    nxt_state = ALLOC;
                end
            end
            DEALLOC: begin
                dq_rd     = 1'b1;
                nxt_state = RD_REQ;
            end
            ALLOC: begin
                // Candidate goes to the queue right away
                aq_wr     = 1'b1;
                cand_take = 1'b1;
                nxt_state = RD_REQ;
            end
            RD_REQ: begin
                // Engine always granted
                upd_rd_req = 1'b1;
                nxt_state  = RD_WAIT;
            end
            RD_WAIT: if (upd_rd_ack) nxt_state = MODIFY;
            MODIFY:  nxt_state = modify_err ? ERROR : WR;
            WR: begin
                wr        = 1'b1;
                nxt_state = DONE;
            end
            DONE:    nxt_state = IDLE;
            ERROR:   nxt_state = IDLE;
            default: nxt_state = RESET;
        endcase
    end

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------
    // Latch operation and pointer
    always_ff @(posedge clk) begin
        if (state == DEALLOC) begin
            is_alloc <= 1'b0;
            ptr      <= dq_ptr;
        end else if (state == ALLOC) begin
            is_alloc <= 1'b1;
            ptr      <= cand_ptr;
        end
    end

    assign ptr_row = ptr[PTR_WID-1 -: ROW_WID];
    assign ptr_col = ptr[COL_WID-1:0];

    always_ff @(posedge clk) begin
        if (upd_rd_req) colmask <= vec_t'(1) << ptr_col;
        if (upd_rd_ack) rd_vec <= rd_data;
    end

    // Bit already at target value
    assign modify_err = is_alloc ? !(|(rd_vec & colmask)) : |(rd_vec & colmask);

    // Clear for alloc, set for dealloc
    always_ff @(posedge clk) begin
        if (state == MODIFY) begin
            wr_data <= is_alloc ? (rd_vec & ~colmask) : (rd_vec | colmask);
        end
    end

    assign upd_rd_row  = ptr_row;
    assign wr_row      = ptr_row;
    assign aq_ptr      = cand_ptr;
    assign err_alloc   = (state == ERROR) && is_alloc;
    assign err_dealloc = (state == ERROR) && !is_alloc;
    assign err_ptr     = ptr;

endmodule

`default_nettype wire

/* verification/ptr_bv_allocator_properties.sv */
// ------------------------------------------------
// Allocator interface properties
// Bound to the top level of the allocator
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ptr_bv_allocator_properties (
    input logic clk,
    input logic local_srst,
    input logic en,
    input logic alloc_rdy,
    input logic err_alloc,
    input logic err_dealloc
);

    // Scanner only offers free pointers
    no_alloc_err: assert property (@(posedge clk) disable iff (local_srst) !err_alloc)
        else $error("err_alloc pulsed");

    // Ready is gated by enable
    rdy_needs_en: assert property (@(posedge clk) disable iff (local_srst) alloc_rdy |-> en)
        else $error("alloc_rdy high while en low");

    // One operation at a time
    one_err_kind: assert property (@(posedge clk) disable iff (local_srst)
                                   !(err_alloc && err_dealloc))
        else $error("err_alloc and err_dealloc high together");

endmodule

bind ptr_bv_allocator ptr_bv_allocator_properties props_i (
    .clk(clk),
    .local_srst(local_srst),
    .en(en),
    .alloc_rdy(alloc_rdy),
    .err_alloc(err_alloc),
    .err_dealloc(err_dealloc)
);

`default_nettype wire

/* verification/ptr_bv_allocator_tb.sv */
// ------------------------------------------------
// Testbench for the bit-vector pointer allocator
// Random alloc and dealloc traffic against a model
// of the pointers the testbench currently owns
// ------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ptr_bv_allocator_tb;
    import alloc_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_PTRS   = 256;
    localparam int MIX_CYCLES = 2000;

    logic clk;
    logic local_srst;
    logic en;
    logic init_done;
    logic alloc_req;
    logic alloc_rdy;
    ptr_t alloc_ptr;
    logic dealloc_req;
    logic dealloc_rdy;
    ptr_t dealloc_ptr;
    logic err_alloc;
    logic err_dealloc;
    ptr_t err_ptr;

    // Reference model with one flag per pointer
    logic owned [NUM_PTRS];
    logic freed [NUM_PTRS];
    int   n_owned;
    int   n_checks;
    int   n_err;
    int   n_err_alloc;
    int   n_err_dealloc;
    ptr_t last_err_ptr;
    logic timed_out;
    // Handshakes seen in the last cycle
    logic got_alloc;
    ptr_t got_ptr;
    logic did_dealloc;

    ptr_bv_allocator #(
        .ALLOC_Q_DEPTH(32),
        .DEALLOC_Q_DEPTH(32)
    ) dut_i (
        .clk(clk), .local_srst(local_srst), .en(en), .init_done(init_done),
        .alloc_req(alloc_req), .alloc_rdy(alloc_rdy), .alloc_ptr(alloc_ptr),
        .dealloc_req(dealloc_req), .dealloc_rdy(dealloc_rdy), .dealloc_ptr(dealloc_ptr),
        .err_alloc(err_alloc), .err_dealloc(err_dealloc), .err_ptr(err_ptr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Error pulses sampled mid-cycle
    always @(negedge clk) begin
        if (local_srst === 1'b0) begin
            if (err_alloc === 1'b1) n_err_alloc++;
            if (err_dealloc === 1'b1) begin
                n_err_dealloc++;
                last_err_ptr = err_ptr;
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_err++;
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_err++;
        timed_out = 1'b1;
        $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
    endtask

    // ------------------------------------------------
    // Stimulus and model helpers
    // ------------------------------------------------
    // Drive after the edge and sample handshakes at the falling edge
    task automatic run_cycle(input logic a_req, input logic d_req, input ptr_t d_ptr);
        alloc_req   = a_req;
        dealloc_req = d_req;
        dealloc_ptr = d_ptr;
        @(negedge clk);
        got_alloc   = alloc_req && alloc_rdy;
        got_ptr     = alloc_ptr;
        did_dealloc = dealloc_req && dealloc_rdy;
        @(posedge clk);
        #1;
    endtask

    // Returned pointer must not be one we already hold
    task automatic record_alloc();
        if (got_alloc) begin
            check_val("owned[alloc_ptr]", owned[got_ptr], 1'b0);
            owned[got_ptr] = 1'b1;
            n_owned++;
        end
    endtask

    task automatic record_dealloc(input ptr_t p);
        if (did_dealloc) begin
            owned[p] = 1'b0;
            n_owned--;
        end
    endtask

    // First owned pointer upward from a random start
    function automatic ptr_t pick_owned();
        int start;
        start = $urandom_range(NUM_PTRS - 1);
        for (int i = 0; i < NUM_PTRS; i++) begin
            if (owned[ptr_t'(start + i)]) return ptr_t'(start + i);
        end
        return ptr_t'(start);
    endfunction

    task automatic alloc_one(output ptr_t p);
        int n;
        n = 0;
        got_alloc = 1'b0;
        while (!got_alloc && n < WAIT_LIMIT && !timed_out) begin
            run_cycle(1'b1, 1'b0, '0);
            n++;
        end
        if (!got_alloc && !timed_out) report_timeout("allocation");
        p = got_ptr;
        record_alloc();
    endtask

    task automatic push_dealloc(input ptr_t p);
        int n;
        n = 0;
        did_dealloc = 1'b0;
        while (!did_dealloc && n < WAIT_LIMIT && !timed_out) begin
            run_cycle(1'b0, 1'b1, p);
            n++;
        end
        if (!did_dealloc && !timed_out) report_timeout("dealloc_rdy");
        record_dealloc(p);
    endtask

    // No pointer handed out even with requests held high
    task automatic expect_no_alloc(input int cycles);
        repeat (cycles) begin
            run_cycle(1'b1, 1'b0, '0);
            check_val("alloc_rdy", got_alloc, 1'b0);
        end
    endtask

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        ptr_t p;
        int   n;
        int   n_freed;
        int   base;
        void'($urandom(32'h92e5));
        local_srst  = 1'b1;
        en          = 1'b1;
        alloc_req   = 1'b0;
        dealloc_req = 1'b0;
        dealloc_ptr = '0;
        timed_out   = 1'b0;
        n_owned     = 0;
        n_freed     = 0;
        for (int i = 0; i < NUM_PTRS; i++) begin
            owned[i] = 1'b0;
            freed[i] = 1'b0;
        end

        // Readies stay low in reset and during the fill
        repeat (RST_CYCLES) begin
            @(posedge clk);
            #1;
            check_val("alloc_rdy", alloc_rdy, 1'b0);
            check_val("dealloc_rdy", dealloc_rdy, 1'b0);
            check_val("init_done", init_done, 1'b0);
        end
        local_srst = 1'b0;
        n = 0;
        while (init_done !== 1'b1 && n < WAIT_LIMIT) begin
            check_val("alloc_rdy", alloc_rdy, 1'b0);
            check_val("dealloc_rdy", dealloc_rdy, 1'b0);
            run_cycle(1'b0, 1'b0, '0);
            n++;
        end
        if (init_done !== 1'b1) report_timeout("init_done");

        // Fresh pool hands out pointers in ascending order
        for (int k = 0; k < NUM_PTRS && !timed_out; k++) begin
            alloc_one(p);
            if (!timed_out) check_val("alloc_ptr", p, k);
        end
        expect_no_alloc(300);

        // Mixed random traffic
        repeat (MIX_CYCLES) begin
            p = (n_owned > 0) ? pick_owned() : '0;
            run_cycle($urandom_range(1), (n_owned > 0) && ($urandom_range(1) == 1), p);
            record_alloc();
            record_dealloc(p);
        end
        check_val("err_dealloc pulses", n_err_dealloc, 0);

        // Take the whole pool back and free a random subset
        while (n_owned < NUM_PTRS && !timed_out) alloc_one(p);
        for (int i = 0; i < NUM_PTRS && !timed_out; i++) begin
            if ($urandom_range(3) == 0) begin
                push_dealloc(ptr_t'(i));
                freed[i] = 1'b1;
                n_freed++;
            end
        end
        // Exactly the freed set comes back
        repeat (n_freed) begin
            alloc_one(p);
            if (!timed_out) begin
                check_val("freed[alloc_ptr]", freed[p], 1'b1);
                freed[p] = 1'b0;
            end
        end
        expect_no_alloc(300);
        check_val("err_dealloc pulses", n_err_dealloc, 0);

        // Second push of a double free is reported
        base = n_err_dealloc;
        p = pick_owned();
        push_dealloc(p);
        run_cycle(1'b0, 1'b1, p);
        check_val("dealloc_rdy", did_dealloc, 1'b1);
        n = 0;
        while (n_err_dealloc == base && n < WAIT_LIMIT) begin
            run_cycle(1'b0, 1'b0, '0);
            n++;
        end
        if (n_err_dealloc == base) report_timeout("err_dealloc pulse");
        check_val("err_ptr", last_err_ptr, p);
        repeat (100) run_cycle(1'b0, 1'b0, '0);
        check_val("err_dealloc pulses", n_err_dealloc, base + 1);

        // Freed pointer refills the allocation queue
        n = 0;
        while (alloc_rdy !== 1'b1 && n < WAIT_LIMIT) begin
            run_cycle(1'b0, 1'b0, '0);
            n++;
        end
        if (alloc_rdy !== 1'b1) report_timeout("alloc_rdy");

        // Enable low blocks both sides
        en = 1'b0;
        repeat (50) begin
            run_cycle(1'b1, 1'b1, '0);
            check_val("alloc_rdy", got_alloc, 1'b0);
            check_val("dealloc_rdy", did_dealloc, 1'b0);
        end
        en = 1'b1;
        run_cycle(1'b0, 1'b0, '0);
        check_val("err_alloc pulses", n_err_alloc, 0);

        $display("Checks: %0d, errors: %0d, err_alloc: %0d, err_dealloc: %0d",
                 n_checks, n_err, n_err_alloc, n_err_dealloc);
        if (n_err == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
